// File: rtl/sci_pkg.sv
package sci_pkg;

	// Register addresses on the CPU bus
	localparam logic [1:0] SCI_ADDR_TX = 2'd0;
	localparam logic [1:0] SCI_ADDR_RX = 2'd1;
	localparam logic [1:0] SCI_ADDR_CFG = 2'd2;

	localparam int SCI_DATA_W = 8;
	localparam int SCI_FIFO_DEPTH = 16;
	localparam int SCI_PTR_W = 4;
	localparam int SCI_CNT_W = 5;
	localparam int SCI_BDR_W = 4;

	// 16 ticks per bit, start + 8 data + stop
	localparam int SCI_OVERSAMPLE = 16;
	localparam int SCI_TICK_W = 4;
	localparam int SCI_FRAME_BITS = 10;

	// Receiver states
	localparam logic [1:0] SCI_RX_IDLE = 2'd0;
	localparam logic [1:0] SCI_RX_START = 2'd1;
	localparam logic [1:0] SCI_RX_DATA = 2'd2;
	localparam logic [1:0] SCI_RX_STOP = 2'd3;

	// Interrupt machine states
	localparam logic SCI_IRQ_IDLE = 1'b0;
	localparam logic SCI_IRQ_BUSY = 1'b1;

	// Config word, ten sits at bit 0
	typedef struct packed {
		logic rcrl;
		logic tcrl;
		logic [2:0] rire;
		logic [2:0] tire;
		logic [SCI_BDR_W-1:0] bdr;
		logic ren;
		logic ten;
	} sci_cfg_t;

	typedef struct packed {
		logic [17:0] rsvd;
		sci_cfg_t cfg;
	} sci_cfg_word_t;

	// TX writes use the low byte, CFG writes the config fields
	typedef union packed {
		logic [31:0] raw;
		sci_cfg_word_t cfg;
	} sci_req_word_u;

	typedef struct packed {
		logic [SCI_CNT_W-1:0] tx_count;
		logic [SCI_CNT_W-1:0] rx_count;
		logic tx_full;
		logic rx_empty;
		logic tx_done;
		logic rx_done;
	} sci_uart_stat_t;

endpackage

// File: rtl/sci_fifo.sv
`timescale 1ns/100ps

module sci_fifo import sci_pkg::*; (
	input logic iIF_CLOCK,
	input logic inRESET,
	input logic clear,
	input logic push,
	input logic [SCI_DATA_W-1:0] push_data,
	input logic pop,
	output logic [SCI_DATA_W-1:0] pop_data,
	output logic [SCI_CNT_W-1:0] count,
	output logic full,
	output logic empty
);

	logic [SCI_DATA_W-1:0] mem [SCI_FIFO_DEPTH];
	logic [SCI_PTR_W-1:0] wr_ptr;
	logic [SCI_PTR_W-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign full = (count == SCI_CNT_W'(SCI_FIFO_DEPTH));
	assign empty = (count == '0);
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// Head entry is visible before the pop
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge iIF_CLOCK) begin
		if (do_push && !clear) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge iIF_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Push and pop together leave the level unchanged
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// File: rtl/sci_baud_gen.sv
`timescale 1ns/100ps

module sci_baud_gen import sci_pkg::*; (
	input logic iIF_CLOCK,
	input logic inRESET,
	input logic [SCI_BDR_W-1:0] bdr,
	output logic tick
);

	logic [SCI_BDR_W-1:0] cnt;

	// One tick every bdr+1 clocks
	assign tick = (cnt == '0);

	always_ff @(posedge iIF_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			cnt <= '0;
		end else if (tick) begin
			// New baud code is picked up here only
			cnt <= bdr;
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

endmodule

// File: rtl/sci_uart_tx.sv
`timescale 1ns/100ps

module sci_uart_tx import sci_pkg::*; (
	input logic iIF_CLOCK,
	input logic inRESET,
	input logic tick,
	input logic enable,
	input logic fifo_empty,
	input logic [SCI_DATA_W-1:0] fifo_data,
	output logic fifo_pop,
	output logic done,
	output logic txd
);

	logic busy;
	logic [SCI_TICK_W-1:0] tick_cnt;
	logic [3:0] bit_cnt;
	logic [SCI_FRAME_BITS-1:0] shreg;
	logic bit_end;

	// Frame starts on a tick while idle
	assign fifo_pop = !busy && tick && enable && !fifo_empty;
	assign bit_end = tick && (tick_cnt == SCI_TICK_W'(SCI_OVERSAMPLE - 1));
	// Shift register idles at all ones, so the line stays high
	assign txd = shreg[0];

	always_ff @(posedge iIF_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			busy <= 1'b0;
			tick_cnt <= '0;
			bit_cnt <= '0;
			shreg <= '1;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (fifo_pop) begin
				busy <= 1'b1;
				tick_cnt <= '0;
				bit_cnt <= '0;
				shreg <= {1'b1, fifo_data, 1'b0};
			end else if (busy && tick) begin
				tick_cnt <= tick_cnt + 1'b1;
				if (bit_end) begin
					shreg <= {1'b1, shreg[SCI_FRAME_BITS-1:1]};
					if (bit_cnt == 4'(SCI_FRAME_BITS - 1)) begin
						// Stop bit finished
						busy <= 1'b0;
						done <= 1'b1;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
			end
		end
	end

endmodule

// File: rtl/sci_uart_rx.sv
`timescale 1ns/100ps

module sci_uart_rx import sci_pkg::*; (
	input logic iIF_CLOCK,
	input logic inRESET,
	input logic tick,
	input logic enable,
	input logic rxd,
	output logic push,
	output logic [SCI_DATA_W-1:0] push_data,
	output logic done
);

	logic [1:0] rxd_sync;
	logic rxd_s;
	logic [1:0] state;
	logic [SCI_TICK_W-1:0] tick_cnt;
	logic [2:0] bit_cnt;
	logic mid_start;
	logic bit_end;

	assign rxd_s = rxd_sync[1];
	assign mid_start = (tick_cnt == SCI_TICK_W'(SCI_OVERSAMPLE / 2 - 1));
	assign bit_end = (tick_cnt == SCI_TICK_W'(SCI_OVERSAMPLE - 1));

	// Line idles high
	always_ff @(posedge iIF_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			rxd_sync <= 2'b11;
		end else begin
			rxd_sync <= {rxd_sync[0], rxd};
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge iIF_CLOCK) begin
		if (tick && state == SCI_RX_DATA && bit_end) begin
			push_data <= {rxd_s, push_data[SCI_DATA_W-1:1]};
		end
	end

	always_ff @(posedge iIF_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= SCI_RX_IDLE;
			tick_cnt <= '0;
			bit_cnt <= '0;
			push <= 1'b0;
			done <= 1'b0;
		end else begin
			push <= 1'b0;
			done <= 1'b0;
			if (!enable) begin
				state <= SCI_RX_IDLE;
			end else if (tick) begin
				tick_cnt <= tick_cnt + 1'b1;
				case (state)
					SCI_RX_IDLE: begin
						if (!rxd_s) begin
							state <= SCI_RX_START;
							tick_cnt <= '0;
						end
					end
					SCI_RX_START: begin
						// Glitch shorter than half a bit is ignored
						if (mid_start) begin
							tick_cnt <= '0;
							bit_cnt <= '0;
							state <= rxd_s ? SCI_RX_IDLE : SCI_RX_DATA;
						end
					end
					SCI_RX_DATA: begin
						if (bit_end) begin
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == 3'(SCI_DATA_W - 1)) begin
								state <= SCI_RX_STOP;
							end
						end
					end
					default: begin
						if (bit_end) begin
							state <= SCI_RX_IDLE;
							done <= 1'b1;
							push <= rxd_s;
						end
					end
				endcase
			end
		end
	end

endmodule

// File: rtl/sci_uart.sv
`timescale 1ns/100ps

module sci_uart import sci_pkg::*; (
	input logic iIF_CLOCK,
	input logic inRESET,
	input sci_cfg_t cfg,
	input logic tx_push,
	input logic [SCI_DATA_W-1:0] tx_data,
	input logic rx_pop,
	output logic [SCI_DATA_W-1:0] rx_data,
	output sci_uart_stat_t stat,
	output logic uart_txd,
	input logic uart_rxd
);

	logic tick;
	logic tx_pop;
	logic tx_empty;
	logic [SCI_DATA_W-1:0] tx_head;
	logic tx_frame_done;
	logic rx_push;
	logic [SCI_DATA_W-1:0] rx_byte;
	logic rx_frame_done;
	logic rx_full;

	sci_baud_gen u_baud (
		.iIF_CLOCK(iIF_CLOCK),
		.inRESET(inRESET),
		.bdr(cfg.bdr),
		.tick(tick)
	);

	sci_fifo u_tx_fifo (
		.iIF_CLOCK(iIF_CLOCK),
		.inRESET(inRESET),
		.clear(cfg.tcrl),
		.push(tx_push),
		.push_data(tx_data),
		.pop(tx_pop),
		.pop_data(tx_head),
		.count(stat.tx_count),
		.full(stat.tx_full),
		.empty(tx_empty)
	);

	sci_fifo u_rx_fifo (
		.iIF_CLOCK(iIF_CLOCK),
		.inRESET(inRESET),
		.clear(cfg.rcrl),
		.push(rx_push),
		.push_data(rx_byte),
		.pop(rx_pop),
		.pop_data(rx_data),
		.count(stat.rx_count),
		.full(rx_full),
		.empty(stat.rx_empty)
	);

	sci_uart_tx u_tx (
		.iIF_CLOCK(iIF_CLOCK),
		.inRESET(inRESET),
		.tick(tick),
		.enable(cfg.ten),
		.fifo_empty(tx_empty),
		.fifo_data(tx_head),
		.fifo_pop(tx_pop),
		.done(tx_frame_done),
		.txd(uart_txd)
	);

	sci_uart_rx u_rx (
		.iIF_CLOCK(iIF_CLOCK),
		.inRESET(inRESET),
		.tick(tick),
		.enable(cfg.ren),
		.rxd(uart_rxd),
		.push(rx_push),
		.push_data(rx_byte),
		.done(rx_frame_done)
	);

	assign stat.tx_done = tx_frame_done;
	// Only count bytes the FIFO really took
	assign stat.rx_done = rx_frame_done && rx_push && !rx_full;

endmodule

// File: rtl/sci_irq.sv
`timescale 1ns/100ps

module sci_irq import sci_pkg::*; (
	input logic iIF_CLOCK,
	input logic inRESET,
	input sci_cfg_t cfg,
	input sci_uart_stat_t stat,
	input logic irq_ack,
	output logic irq_valid
);

	logic state;
	logic tx_flag;
	logic tx_wait;
	logic [SCI_CNT_W-1:0] tx_thr;
	logic rx_flag;
	logic rx_wait;
	logic [SCI_CNT_W-1:0] rx_thr;
	logic [SCI_CNT_W-1:0] tx_level;
	logic [SCI_CNT_W-1:0] rx_level;
	logic [SCI_CNT_W-1:0] rx_next;
	logic take_tx;
	logic take_rx;

	// Zero means the code never raises the flag
	function automatic logic [SCI_CNT_W-1:0] tx_table(input logic [2:0] code);
		case (code)
			3'd1: return SCI_CNT_W'(1);
			3'd2: return SCI_CNT_W'(2);
			3'd3: return SCI_CNT_W'(4);
			3'd4: return SCI_CNT_W'(8);
			default: return '0;
		endcase
	endfunction

	function automatic logic [SCI_CNT_W-1:0] rx_table(input logic [2:0] code);
		case (code)
			3'd1: return SCI_CNT_W'(1);
			3'd2: return SCI_CNT_W'(2);
			3'd3: return SCI_CNT_W'(4);
			3'd4: return SCI_CNT_W'(8);
			3'd5: return SCI_CNT_W'(15);
			default: return '0;
		endcase
	endfunction

	assign tx_level = tx_table(cfg.tire);
	assign rx_level = rx_table(cfg.rire);

	// Level once the byte marked by rx_done is stored
	assign rx_next = stat.rx_count + 1'b1;

	// Receive side wins when both are pending
	assign take_rx = (state == SCI_IRQ_IDLE) && rx_flag;
	assign take_tx = (state == SCI_IRQ_IDLE) && !rx_flag && tx_flag;

	// Transmit level low enough after a frame
	always_ff @(posedge iIF_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			tx_flag <= 1'b0;
			tx_wait <= 1'b0;
			tx_thr <= '0;
		end else if (take_tx) begin
			tx_flag <= 1'b0;
			tx_wait <= 1'b1;
		end else if (tx_wait) begin
			if (stat.tx_count > tx_thr) begin
				tx_wait <= 1'b0;
			end
		end else if (!tx_flag && stat.tx_done && tx_level != '0 &&
				stat.tx_count <= tx_level) begin
			tx_flag <= 1'b1;
			tx_thr <= tx_level;
		end
	end

	// Receive level high enough after a byte
	always_ff @(posedge iIF_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			rx_flag <= 1'b0;
			rx_wait <= 1'b0;
			rx_thr <= '0;
		end else if (take_rx) begin
			rx_flag <= 1'b0;
			rx_wait <= 1'b1;
		end else if (rx_wait) begin
			if (stat.rx_count < rx_thr) begin
				rx_wait <= 1'b0;
			end
		end else if (!rx_flag && stat.rx_done && rx_level != '0 &&
				rx_next >= rx_level) begin
			rx_flag <= 1'b1;
			rx_thr <= rx_level;
		end
	end

	always_ff @(posedge iIF_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= SCI_IRQ_IDLE;
		end else if (state == SCI_IRQ_IDLE) begin
			if (take_rx || take_tx) begin
				state <= SCI_IRQ_BUSY;
			end
		end else if (irq_ack) begin
			state <= SCI_IRQ_IDLE;
		end
	end

	assign irq_valid = (state == SCI_IRQ_BUSY);

endmodule

// File: rtl/sci_peripheral.sv
`timescale 1ns/100ps

module sci_peripheral import sci_pkg::*; (
	input logic iIF_CLOCK,
	input logic inRESET,
	// CPU bus
	input logic req_valid,
	input logic req_rw,
	input logic [1:0] req_addr,
	input sci_req_word_u req_data,
	output logic req_busy,
	output logic rsp_valid,
	output logic [31:0] rsp_data,
	// Interrupt
	output logic irq_valid,
	input logic irq_ack,
	// Serial line
	output logic uart_txd,
	input logic uart_rxd
);

	sci_cfg_t cfg_q;
	sci_uart_stat_t stat;
	logic [SCI_DATA_W-1:0] rx_data;
	logic cfg_wr;
	logic tx_push;
	logic rx_pop;

	assign cfg_wr = req_valid && req_rw && (req_addr == SCI_ADDR_CFG);
	// Write into a full FIFO is dropped
	assign tx_push = req_valid && req_rw && (req_addr == SCI_ADDR_TX) && !stat.tx_full;
	assign rx_pop = req_valid && !req_rw && (req_addr == SCI_ADDR_RX) && !stat.rx_empty;

	always_ff @(posedge iIF_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			cfg_q <= '0;
		end else if (cfg_wr) begin
			cfg_q <= req_data.cfg.cfg;
		end else begin
			// Clears only last one cycle
			cfg_q.tcrl <= 1'b0;
			cfg_q.rcrl <= 1'b0;
		end
	end

	sci_uart u_uart (
		.iIF_CLOCK(iIF_CLOCK),
		.inRESET(inRESET),
		.cfg(cfg_q),
		.tx_push(tx_push),
		.tx_data(req_data.raw[SCI_DATA_W-1:0]),
		.rx_pop(rx_pop),
		.rx_data(rx_data),
		.stat(stat),
		.uart_txd(uart_txd),
		.uart_rxd(uart_rxd)
	);

	sci_irq u_irq (
		.iIF_CLOCK(iIF_CLOCK),
		.inRESET(inRESET),
		.cfg(cfg_q),
		.stat(stat),
		.irq_ack(irq_ack),
		.irq_valid(irq_valid)
	);

	assign req_busy = stat.tx_full;
	assign rsp_valid = rx_pop;
	// Bit 31 marks a valid byte
	assign rsp_data = stat.rx_empty ? 32'h0 : {1'b1, 23'h0, rx_data};

endmodule

// File: testbench/sci_tb.sv
`timescale 1ns/100ps

module sci_tb import sci_pkg::*; ();

	typedef enum logic [2:0] {
		OP_CFG, OP_TX, OP_RX, OP_WAIT_RX, OP_WAIT_IRQ, OP_ACK, OP_IDLE
	} op_e;

	// irq and busy are compared one cycle after the drive
	typedef struct packed {
		op_e op;
		logic [31:0] data;
		logic rsp_valid;
		logic irq_valid;
		logic req_busy;
	} step_t;

	logic iIF_CLOCK;
	logic inRESET;
	logic req_valid;
	logic req_rw;
	logic [1:0] req_addr;
	sci_req_word_u req_data;
	logic req_busy;
	logic rsp_valid;
	logic [31:0] rsp_data;
	logic irq_valid;
	logic irq_ack;
	logic uart_line;

	step_t steps[$];
	logic [7:0] expected_rx[$];
	int seed = 32'h8f93_0a5c;
	int errors = 0;
	int checks = 0;
	int wait_limit = 2000;
	bit table_built = 0;

	// TXD looped back to RXD
	sci_peripheral DUT (
		.iIF_CLOCK(iIF_CLOCK),
		.inRESET(inRESET),
		.req_valid(req_valid),
		.req_rw(req_rw),
		.req_addr(req_addr),
		.req_data(req_data),
		.req_busy(req_busy),
		.rsp_valid(rsp_valid),
		.rsp_data(rsp_data),
		.irq_valid(irq_valid),
		.irq_ack(irq_ack),
		.uart_txd(uart_line),
		.uart_rxd(uart_line)
	);

	always #4 iIF_CLOCK = ~iIF_CLOCK;

	task automatic add_step(input op_e op, input logic [31:0] data, input logic vld,
			input logic irq, input logic busy);
		step_t s;
		s.op = op;
		s.data = data;
		s.rsp_valid = vld;
		s.irq_valid = irq;
		s.req_busy = busy;
		steps.push_back(s);
	endtask

	// Config word bits ten 0, ren 1, tire 8:6, rire 11:9, tcrl 12, rcrl 13
	task automatic build_table();
		int i;
		add_step(OP_RX, 0, 0, 0, 0);
		// Loopback order
		add_step(OP_CFG, 32'h0000_0003, 0, 0, 0);
		for (i = 0; i < 3; i++)
			add_step(OP_TX, 1, 0, 0, 0);
		add_step(OP_WAIT_RX, 3, 0, 0, 0);
		for (i = 0; i < 3; i++)
			add_step(OP_RX, 0, 1, 0, 0);
		add_step(OP_RX, 0, 0, 0, 0);
		// Fill the transmit FIFO with the shifter off
		add_step(OP_CFG, 32'h0000_0002, 0, 0, 0);
		for (i = 0; i < 15; i++)
			add_step(OP_TX, 0, 0, 0, 0);
		add_step(OP_TX, 0, 0, 0, 1);
		add_step(OP_TX, 0, 0, 0, 1);
		// Clear lands one edge after the config write
		add_step(OP_CFG, 32'h0000_1002, 0, 0, 1);
		add_step(OP_IDLE, 2, 0, 0, 0);
		add_step(OP_CFG, 32'h0000_0003, 0, 0, 0);
		add_step(OP_IDLE, 400, 0, 0, 0);
		add_step(OP_RX, 0, 0, 0, 0);
		// Receive interrupt at level 4
		add_step(OP_CFG, 32'h0000_0603, 0, 0, 0);
		for (i = 0; i < 4; i++)
			add_step(OP_TX, 1, 0, 0, 0);
		// Three bytes stored must not raise it yet
		add_step(OP_WAIT_RX, 3, 0, 0, 0);
		add_step(OP_WAIT_IRQ, 0, 0, 1, 0);
		add_step(OP_IDLE, 20, 0, 1, 0);
		add_step(OP_ACK, 0, 0, 0, 0);
		for (i = 0; i < 4; i++)
			add_step(OP_RX, 0, 1, 0, 0);
		add_step(OP_RX, 0, 0, 0, 0);
		// Transmit interrupt at level 2
		add_step(OP_CFG, 32'h0000_0083, 0, 0, 0);
		for (i = 0; i < 5; i++)
			add_step(OP_TX, 1, 0, 0, 0);
		add_step(OP_WAIT_IRQ, 0, 0, 1, 0);
		add_step(OP_ACK, 0, 0, 0, 0);
		add_step(OP_WAIT_RX, 5, 0, 0, 0);
		for (i = 0; i < 5; i++)
			add_step(OP_RX, 0, 1, 0, 0);
		add_step(OP_RX, 0, 0, 0, 0);
		// Receiver off and a filled receive FIFO cleared
		add_step(OP_CFG, 32'h0000_0001, 0, 0, 0);
		add_step(OP_TX, 0, 0, 0, 0);
		add_step(OP_TX, 0, 0, 0, 0);
		add_step(OP_IDLE, 400, 0, 0, 0);
		add_step(OP_RX, 0, 0, 0, 0);
		add_step(OP_CFG, 32'h0000_0003, 0, 0, 0);
		for (i = 0; i < 3; i++)
			add_step(OP_TX, 0, 0, 0, 0);
		add_step(OP_WAIT_RX, 3, 0, 0, 0);
		add_step(OP_CFG, 32'h0000_2003, 0, 0, 0);
		add_step(OP_IDLE, 2, 0, 0, 0);
		add_step(OP_RX, 0, 0, 0, 0);
	endtask

	task automatic run_step(input int idx, input step_t s);
		logic [31:0] rnd;
		logic [31:0] exp_data;
		int waited;
		waited = 0;
		exp_data = '0;
		case (s.op)
			OP_CFG: begin
				req_valid = 1'b1;
				req_rw = 1'b1;
				req_addr = SCI_ADDR_CFG;
				req_data.raw = s.data;
			end
			OP_TX: begin
				rnd = $random(seed);
				req_valid = 1'b1;
				req_rw = 1'b1;
				req_addr = SCI_ADDR_TX;
				req_data.raw = {24'h0, rnd[7:0]};
				// Only bytes that must come back go to the shadow queue
				if (s.data[0]) begin
					expected_rx.push_back(rnd[7:0]);
				end
			end
			OP_RX: begin
				req_valid = 1'b1;
				req_rw = 1'b0;
				req_addr = SCI_ADDR_RX;
			end
			OP_ACK: begin
				irq_ack = 1'b1;
			end
			OP_WAIT_RX: begin
				while (DUT.u_uart.u_rx_fifo.count < s.data[4:0] && waited < wait_limit) begin
					@(negedge iIF_CLOCK);
					waited++;
				end
				if (DUT.u_uart.u_rx_fifo.count < s.data[4:0]) begin
					$display("Step %0d timed out waiting for %0d received bytes", idx, s.data);
					errors++;
				end
			end
			OP_WAIT_IRQ: begin
				while (irq_valid !== 1'b1 && waited < wait_limit) begin
					@(negedge iIF_CLOCK);
					waited++;
				end
				if (irq_valid !== 1'b1) begin
					$display("Step %0d timed out waiting for the interrupt", idx);
					errors++;
				end
			end
			default: begin
				repeat (s.data) @(negedge iIF_CLOCK);
			end
		endcase
		// Sample the combinational read response well before the edge
		#2;
		if (s.op == OP_RX) begin
			checks++;
			if (s.rsp_valid) begin
				if (expected_rx.size() == 0) begin
					$display("Step %0d expects read data but no byte is left to compare", idx);
					errors++;
				end else begin
					exp_data = {1'b1, 23'h0, expected_rx.pop_front()};
				end
			end
			if (rsp_valid !== s.rsp_valid) begin
				$display("Fail %0t: step %0d rsp_valid %b, expected %b", $time, idx,
					rsp_valid, s.rsp_valid);
				errors++;
			end
			if (rsp_data !== exp_data) begin
				$display("Fail %0t: step %0d rsp_data %h, expected %h", $time, idx,
					rsp_data, exp_data);
				errors++;
			end
		end
		@(negedge iIF_CLOCK);
		req_valid = 1'b0;
		req_rw = 1'b0;
		req_addr = '0;
		req_data.raw = '0;
		irq_ack = 1'b0;
		checks++;
		if (irq_valid !== s.irq_valid) begin
			$display("Fail %0t: step %0d irq_valid %b, expected %b", $time, idx,
				irq_valid, s.irq_valid);
			errors++;
		end
		if (req_busy !== s.req_busy) begin
			$display("Fail %0t: step %0d req_busy %b, expected %b", $time, idx,
				req_busy, s.req_busy);
			errors++;
		end
	endtask

	initial begin
		int i;
		iIF_CLOCK = 1'b0;
		inRESET = 1'b0;
		req_valid = 1'b0;
		req_rw = 1'b0;
		req_addr = '0;
		req_data.raw = '0;
		irq_ack = 1'b0;
		build_table();
		table_built = 1'b1;
		repeat (4) @(posedge iIF_CLOCK);
		@(negedge iIF_CLOCK);
		inRESET = 1'b1;
		checks++;
		if (uart_line !== 1'b1) begin
			$display("Fail %0t: uart_txd %b after reset, expected 1", $time, uart_line);
			errors++;
		end
		for (i = 0; i < steps.size(); i++) begin
			run_step(i, steps[i]);
		end
		$display("Finished %0d checks with %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// Budget of 400 cycles per table row
	initial begin
		longint limit_ns;
		wait (table_built);
		limit_ns = steps.size() * 400 * 8;
		#(limit_ns);
		$display("Watchdog expired after %0d ns before the table finished", limit_ns);
		$display("TEST FAIL");
		$finish;
	end

endmodule

// File: sources.f
rtl/sci_pkg.sv
rtl/sci_fifo.sv
rtl/sci_baud_gen.sv
rtl/sci_uart_tx.sv
rtl/sci_uart_rx.sv
rtl/sci_uart.sv
rtl/sci_irq.sv
rtl/sci_peripheral.sv
testbench/sci_tb.sv

// File: Bender.yml
package:
  name: sci

sources:
  - rtl/sci_pkg.sv
  - rtl/sci_fifo.sv
  - rtl/sci_baud_gen.sv
  - rtl/sci_uart_tx.sv
  - rtl/sci_uart_rx.sv
  - rtl/sci_uart.sv
  - rtl/sci_irq.sv
  - rtl/sci_peripheral.sv
  - target: test
    files:
      - testbench/sci_tb.sv
